/* rtl/answer_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module answer_unit import quiz_pkg::*; (
    input  quiz_mode_t mode,
    input  quiz_op_t   op,
    input  operand_t   a,
    input  operand_t   b,
    output operand_t   result
);

    logic [2:0]        shamt;           // shift count, low bits of b
    logic signed [7:0] a_signed;
    logic              a_true;
    logic              b_true;

    assign shamt    = b[2:0];
    assign a_signed = a;
    assign a_true   = |a;
    assign b_true   = |b;

    always_comb begin
        result = '0;
        case (mode)
            MODE_SHIFT: begin
                case (op)
                    OP_1: result = a <<< shamt;
                    OP_2: result = a_signed >>> shamt;  // sign fill
                    OP_3: result = a << shamt;
                    OP_4: result = a >> shamt;
                endcase
            end
            MODE_BITWISE: begin
                case (op)
                    OP_1: result = a & b;
                    OP_2: result = a | b;
                    OP_3: result = ~a;
                    OP_4: result = a ^ b;
                endcase
            end
            MODE_LOGIC: begin
                // true is all ones
                case (op)
                    OP_1: result = {8{a_true && b_true}};
                    OP_2: result = {8{a_true || b_true}};
                    OP_3: result = {8{!a_true}};
                    OP_4: result = {8{a_true ^ b_true}};
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mode_tally.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_tally import quiz_pkg::*; #(
    parameter int unsigned COUNT_MAX = 99
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   strobe,
    input  logic   correct,
    output tally_t tally
);

    localparam tally_count_t CAP = tally_count_t'(COUNT_MAX);

    tally_count_t attempts_next;
    tally_count_t correct_next;
    logic [15:0]  scaled;               // correct count times 100
    percent_t     percent_next;

    always_comb begin
        attempts_next = tally.attempts;
        correct_next  = tally.correct;
        if (tally.attempts != CAP)
            attempts_next = tally.attempts + 8'd1;
        if (correct && tally.correct != CAP)
            correct_next = tally.correct + 8'd1;
    end

    assign scaled = {8'd0, correct_next} * 16'd100;

    // correct never exceeds attempts, so the quotient fits in 7 bits
    assign percent_next = (attempts_next == '0) ? '0
                        : percent_t'(scaled / {8'd0, attempts_next});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tally <= '0;
        end else if (strobe) begin
            tally <= '{
                attempts: attempts_next,
                correct:  correct_next,
                percent:  percent_next
            };
        end
    end

endmodule

`default_nettype wire

/* rtl/quiz_control.sv */
`timescale 1ns/1ps
`default_nettype none

module quiz_control import quiz_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 confirm,
    input  logic                 exit,
    input  logic                 select,
    input  logic                 data,
    input  operand_t             in,
    output logic                 mode_entered,
    output quiz_view_t           view,
    output logic [NUM_MODES-1:0] tally_strobe,
    output logic                 tally_correct
);

    quiz_mode_t mode;
    quiz_mode_t stats_mode;
    quiz_op_t   op;
    quiz_step_t step;
    logic       stats_view;
    logic       verdict_ok;
    operand_t   a;
    operand_t   b;
    operand_t   result;                 // reference answer
    logic       answer_done;            // answer confirmed this cycle

    function automatic quiz_mode_t next_mode(input quiz_mode_t m);
        return (m == MODE_LOGIC) ? MODE_SHIFT : quiz_mode_t'(m + 2'd1);
    endfunction

    answer_unit u_answer (
        .mode   (mode),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result)
    );

    assign answer_done = mode_entered && !exit && confirm && (step == STEP_ENTER_ANSWER);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_entered <= 1'b0;
            stats_view   <= 1'b0;
            mode         <= MODE_SHIFT;
            stats_mode   <= MODE_SHIFT;
            op           <= OP_1;
            step         <= STEP_IDLE;
        end else if (!mode_entered) begin
            if (stats_view) begin
                // confirm has no effect here
                if (select)
                    stats_mode <= next_mode(stats_mode);
                if (data)
                    stats_view <= 1'b0;
            end else begin
                if (select)
                    mode <= next_mode(mode);
                if (confirm) begin
                    mode_entered <= 1'b1;
                    op           <= OP_1;
                    step         <= STEP_IDLE;
                end else if (data) begin
                    stats_view <= 1'b1;
                end
            end
        end else if (exit) begin
            mode_entered <= 1'b0;       // abandon question, no tally
            step         <= STEP_IDLE;
        end else begin
            if (select && step == STEP_IDLE)
                op <= quiz_op_t'(op + 2'd1);  // wraps after OP_4
            if (confirm) begin
                case (step)
                    STEP_IDLE:         step <= STEP_ENTER_A;
                    STEP_ENTER_A:      step <= STEP_ENTER_B;
                    STEP_ENTER_B:      step <= STEP_ENTER_ANSWER;
                    STEP_ENTER_ANSWER: step <= STEP_VERDICT;
                    default:           step <= STEP_IDLE;
                endcase
            end
        end
    end

    // operands follow the switches while their step is active
    always_ff @(posedge clk) begin
        if (step == STEP_ENTER_A)
            a <= in;
        if (step == STEP_ENTER_B)
            b <= in;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            verdict_ok   <= 1'b0;
            tally_strobe <= '0;
        end else begin
            tally_strobe <= '0;
            if (answer_done) begin
                verdict_ok         <= (in == result);
                tally_strobe[mode] <= 1'b1;  // lane of the current mode
            end
        end
    end

    assign tally_correct = verdict_ok;

    assign view = '{
        in_mode:    mode_entered,
        stats_view: stats_view,
        mode:       mode,
        stats_mode: stats_mode,
        op:         op,
        step:       step,
        verdict_ok: verdict_ok
    };

endmodule

`default_nettype wire

/* rtl/quiz_pkg.sv */
`default_nettype none

package quiz_pkg;

    typedef logic [7:0] operand_t;      // operand, answer or result
    typedef logic [7:0] tally_count_t;  // attempts or correct answers
    typedef logic [6:0] percent_t;      // 0 to 100
    typedef logic [7:0] seg_t;          // segments a..g then dp, active high

    localparam int NUM_MODES = 3;       // one tally lane per mode

    typedef enum logic [1:0] {
        MODE_SHIFT   = 2'd0,            // shown as 1
        MODE_BITWISE = 2'd1,
        MODE_LOGIC   = 2'd2
    } quiz_mode_t;

    // meaning of each op depends on the mode
    typedef enum logic [1:0] {
        OP_1 = 2'd0,
        OP_2 = 2'd1,
        OP_3 = 2'd2,
        OP_4 = 2'd3
    } quiz_op_t;

    typedef enum logic [2:0] {
        STEP_IDLE         = 3'd0,
        STEP_ENTER_A      = 3'd1,
        STEP_ENTER_B      = 3'd2,
        STEP_ENTER_ANSWER = 3'd3,
        STEP_VERDICT      = 3'd4
    } quiz_step_t;

    typedef struct packed {
        tally_count_t attempts;
        tally_count_t correct;
        percent_t     percent;          // correct*100/attempts, rounded down
    } tally_t;

    typedef struct packed {
        logic       in_mode;
        logic       stats_view;
        quiz_mode_t mode;
        quiz_mode_t stats_mode;         // lane shown in the stats view
        quiz_op_t   op;
        quiz_step_t step;
        logic       verdict_ok;
    } quiz_view_t;

    typedef seg_t [1:8] seg_bank_t;     // digit 1 in the top byte

    localparam seg_t SEG_BLANK       = 8'b0000_0000;
    localparam seg_t SEG_PROMPT_A    = 8'b0011_1010;
    localparam seg_t SEG_PROMPT_B    = 8'b0011_1110;
    localparam seg_t SEG_PROMPT_R    = 8'b1000_1100;
    localparam seg_t SEG_VERDICT_OK  = 8'b1110_1110;  // "A"
    localparam seg_t SEG_VERDICT_BAD = 8'b1001_1110;  // "E"

    function automatic seg_t digit_segments(input logic [7:0] value);
        case (value)
            8'd0:    return 8'b1111_1100;
            8'd1:    return 8'b0110_0000;
            8'd2:    return 8'b1101_1010;
            8'd3:    return 8'b1111_0010;
            8'd4:    return 8'b0110_0110;
            8'd5:    return 8'b1011_0110;
            8'd6:    return 8'b1011_1110;
            8'd7:    return 8'b1110_0000;
            8'd8:    return 8'b1111_1110;
            8'd9:    return 8'b1111_0110;
            default: return SEG_BLANK;  // not a decimal digit
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/quiz_trainer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module quiz_trainer_top import quiz_pkg::*; #(
    parameter int unsigned COUNT_MAX = 99   // tally saturation
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      confirm,
    input  logic      exit,
    input  logic      select,
    input  logic      data,
    input  operand_t  in,
    output logic      mode_entered,
    output seg_bank_t seg
);

    quiz_view_t             view;
    logic [NUM_MODES-1:0]   tally_strobe;
    logic                   tally_correct;
    tally_t [NUM_MODES-1:0] tallies;

    quiz_control u_control (
        .clk           (clk),
        .arst_n        (arst_n),
        .confirm       (confirm),
        .exit          (exit),
        .select        (select),
        .data          (data),
        .in            (in),
        .mode_entered  (mode_entered),
        .view          (view),
        .tally_strobe  (tally_strobe),
        .tally_correct (tally_correct)
    );

    // one lane per mode, indexed by the mode encoding
    for (genvar i = 0; i < NUM_MODES; i++) begin : g_tally
        mode_tally #(
            .COUNT_MAX (COUNT_MAX)
        ) u_tally (
            .clk     (clk),
            .arst_n  (arst_n),
            .strobe  (tally_strobe[i]),
            .correct (tally_correct),
            .tally   (tallies[i])
        );
    end

    seg_display u_display (
        .clk     (clk),
        .arst_n  (arst_n),
        .view    (view),
        .tallies (tallies),
        .seg     (seg)
    );

endmodule

`default_nettype wire

/* rtl/seg_display.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_display import quiz_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  quiz_view_t             view,
    input  tally_t [NUM_MODES-1:0] tallies,
    output seg_bank_t              seg
);

    tally_t     shown;                  // lane picked in the stats view
    logic [7:0] mode_num;
    logic [7:0] stats_num;
    logic [7:0] op_num;
    logic [7:0] pct;
    logic [7:0] att_tens;
    logic [7:0] att_ones;
    logic [7:0] pct_hund;
    logic [7:0] pct_tens;
    logic [7:0] pct_ones;
    seg_bank_t  seg_next;

    assign shown     = tallies[view.stats_mode];
    assign mode_num  = {6'd0, view.mode} + 8'd1;       // modes count from 1
    assign stats_num = {6'd0, view.stats_mode} + 8'd1;
    assign op_num    = {6'd0, view.op} + 8'd1;
    assign pct       = {1'b0, shown.percent};

    assign att_tens = shown.attempts / 8'd10;
    assign att_ones = shown.attempts % 8'd10;
    assign pct_hund = pct / 8'd100;
    assign pct_tens = (pct / 8'd10) % 8'd10;
    assign pct_ones = pct % 8'd10;

    always_comb begin
        seg_next = {8{SEG_BLANK}};
        if (view.in_mode) begin
            seg_next[1] = digit_segments(mode_num);
            seg_next[2] = digit_segments(op_num);
            case (view.step)
                STEP_ENTER_A: begin
                    seg_next[3] = SEG_PROMPT_A;
                end
                STEP_ENTER_B: begin
                    seg_next[3] = SEG_PROMPT_A;
                    seg_next[4] = SEG_PROMPT_B;
                end
                STEP_ENTER_ANSWER: begin
                    seg_next[5] = SEG_PROMPT_R;
                end
                STEP_VERDICT: begin
                    seg_next[8] = view.verdict_ok ? SEG_VERDICT_OK : SEG_VERDICT_BAD;
                end
                default: ;                  // idle shows mode and op only
            endcase
        end else if (view.stats_view) begin
            seg_next[1] = digit_segments(stats_num);
            seg_next[3] = digit_segments(att_tens);  // attempt count
            seg_next[4] = digit_segments(att_ones);
            seg_next[6] = digit_segments(pct_hund);  // percentage
            seg_next[7] = digit_segments(pct_tens);
            seg_next[8] = digit_segments(pct_ones);
        end else begin
            seg_next[1] = digit_segments(mode_num);  // browse
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            seg <= '0;
        else
            seg <= seg_next;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the quiz trainer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_quiz_trainer

verilator --binary --timing -f verilog.f --top-module tb_quiz_trainer \
    -Mdir obj_dir -o sim_quiz_trainer
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

/* testbench/quiz_vectors.txt */
# columns: mode op a b answer correct, all in hex
# mode 0 shift, 1 bitwise, 2 logic; op 0 to 3; correct is 1 for a right answer
0 0 35 03 a8 1
1 0 cc aa 88 1
2 0 04 00 00 1
0 1 96 02 e5 1
1 1 0f 30 3f 1
2 1 00 80 ff 1
0 2 81 01 02 1
1 2 5a 00 a5 1
2 2 00 00 01 0
0 3 f0 0c 0f 1
1 3 ff 0f ff 0
2 3 10 20 00 1
0 0 11 04 11 0
0 1 96 0a 25 0
0 3 80 07 00 0
1 1 12 21 30 0
2 0 01 02 ff 1

/* testbench/tb_quiz_trainer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_quiz_trainer import quiz_pkg::*; ();

    typedef struct packed {
        logic [1:0] mode;
        logic [1:0] op;
        operand_t   a;
        operand_t   b;
        operand_t   answer;
        logic       correct;            // flag from the vector file
    } quiz_vector_t;

    localparam int CONFIRM_BTN = 0;
    localparam int EXIT_BTN    = 1;
    localparam int SELECT_BTN  = 2;
    localparam int DATA_BTN    = 3;

    logic         clk;
    logic         arst_n;
    logic         confirm;
    logic         exit;
    logic         select;
    logic         data;
    operand_t     in;
    logic         mode_entered;
    seg_bank_t    seg;

    quiz_vector_t vectors[$];
    logic [1:0]   cur_mode;             // mode shown in the browse view
    int           attempts_exp[NUM_MODES];
    int           correct_exp[NUM_MODES];
    int           error_count;
    int           check_count;
    int unsigned  cycle_count = 0;
    int unsigned  cycle_limit = 600;

    quiz_trainer_top #(
        .COUNT_MAX (99)
    ) uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .confirm      (confirm),
        .exit         (exit),
        .select       (select),
        .data         (data),
        .in           (in),
        .mode_entered (mode_entered),
        .seg          (seg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hard stop on a hung run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_display(input string name, input seg_bank_t expected);
        check_value(name, expected, seg);
    endtask

    function automatic operand_t reference_result(input logic [1:0] mode, input logic [1:0] op,
                                                  input operand_t a, input operand_t b);
        logic [2:0] count;
        operand_t   fill;
        logic       a_nz;
        logic       b_nz;
        logic       truth;
        count = b[2:0];
        a_nz  = (a != 8'h00);
        b_nz  = (b != 8'h00);
        fill  = a[7] ? ~(8'hff >> count) : 8'h00;  // sign bits for the right shift
        truth = 1'b0;
        case (mode)
            2'd0: begin
                case (op)
                    2'd0:    return a << count;
                    2'd1:    return (a >> count) | fill;
                    2'd2:    return a << count;
                    default: return a >> count;
                endcase
            end
            2'd1: begin
                case (op)
                    2'd0:    return a & b;
                    2'd1:    return a | b;
                    2'd2:    return ~a;
                    default: return a ^ b;
                endcase
            end
            default: begin
                case (op)
                    2'd0:    truth = a_nz && b_nz;
                    2'd1:    truth = a_nz || b_nz;
                    2'd2:    truth = !a_nz;
                    default: truth = a_nz != b_nz;
                endcase
                return truth ? 8'hff : 8'h00;
            end
        endcase
    endfunction

    function automatic seg_bank_t browse_bank(input logic [1:0] mode);
        seg_bank_t bank;
        bank    = '0;
        bank[1] = digit_segments({6'd0, mode} + 8'd1);
        return bank;
    endfunction

    function automatic seg_bank_t question_bank(input logic [1:0] mode, input logic [1:0] op,
                                                input quiz_step_t step, input logic ok);
        seg_bank_t bank;
        bank    = '0;
        bank[1] = digit_segments({6'd0, mode} + 8'd1);
        bank[2] = digit_segments({6'd0, op} + 8'd1);
        if (step == STEP_ENTER_A || step == STEP_ENTER_B)
            bank[3] = SEG_PROMPT_A;
        if (step == STEP_ENTER_B)
            bank[4] = SEG_PROMPT_B;
        if (step == STEP_ENTER_ANSWER)
            bank[5] = SEG_PROMPT_R;
        if (step == STEP_VERDICT)
            bank[8] = ok ? SEG_VERDICT_OK : SEG_VERDICT_BAD;
        return bank;
    endfunction

    function automatic seg_bank_t stats_bank(input logic [1:0] mode, input int attempts,
                                             input int percent);
        seg_bank_t bank;
        bank    = '0;
        bank[1] = digit_segments({6'd0, mode} + 8'd1);
        bank[3] = digit_segments(8'(attempts / 10));
        bank[4] = digit_segments(8'(attempts % 10));
        bank[6] = digit_segments(8'(percent / 100));
        bank[7] = digit_segments(8'((percent / 10) % 10));
        bank[8] = digit_segments(8'(percent % 10));
        return bank;
    endfunction

    task automatic load_vectors();
        int                 fd;
        int                 count;
        int                 f_mode;
        int                 f_op;
        int                 f_a;
        int                 f_b;
        int                 f_answer;
        int                 f_correct;
        logic [8*128-1:0]   skip_line;
        quiz_vector_t       v;
        bit                 done;
        fd = $fopen("testbench/quiz_vectors.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the vector file testbench/quiz_vectors.txt");
            return;
        end
        done = 1'b0;
        while (!done) begin
            count = $fscanf(fd, "%h %h %h %h %h %h", f_mode, f_op, f_a, f_b, f_answer, f_correct);
            if (count == 6) begin
                if (f_mode >= NUM_MODES || f_op > 3) begin
                    error_count++;
                    $display("Vector file holds a mode or operator out of range");
                end else begin
                    v.mode    = 2'(f_mode);
                    v.op      = 2'(f_op);
                    v.a       = 8'(f_a);
                    v.b       = 8'(f_b);
                    v.answer  = 8'(f_answer);
                    v.correct = (f_correct != 0);
                    vectors.push_back(v);
                end
            end else if (count == 0) begin
                if ($fgets(skip_line, fd) == 0)  // comment line or end of file
                    done = 1'b1;
            end else if (count < 0) begin
                done = 1'b1;
            end else begin
                error_count++;
                $display("Vector file holds an incomplete line");
                done = 1'b1;
            end
        end
        $fclose(fd);
    endtask

    // one-cycle pulse, then three idle cycles for seg to settle
    task automatic press_button(input int button);
        case (button)
            CONFIRM_BTN: confirm = 1'b1;
            EXIT_BTN:    exit    = 1'b1;
            SELECT_BTN:  select  = 1'b1;
            default:     data    = 1'b1;
        endcase
        @(posedge clk);
        #1;
        confirm = 1'b0;
        exit    = 1'b0;
        select  = 1'b0;
        data    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic step_browse_mode();
        press_button(SELECT_BTN);
        cur_mode = (cur_mode == 2'd2) ? 2'd0 : cur_mode + 2'd1;
    endtask

    task automatic select_browse_mode(input logic [1:0] target);
        while (cur_mode != target)
            step_browse_mode();
    endtask

    task automatic run_question(input int index);
        quiz_vector_t v;
        operand_t     expected;
        string        tag;
        int unsigned  extra;
        v        = vectors[index];
        tag      = $sformatf("vector %0d", index);
        expected = reference_result(v.mode, v.op, v.a, v.b);
        check_value({tag, " flag in file"}, 64'(v.answer == expected), 64'(v.correct));
        select_browse_mode(v.mode);
        press_button(CONFIRM_BTN);
        check_value({tag, " mode entered"}, 64'(1'b1), 64'(mode_entered));
        repeat (v.op) press_button(SELECT_BTN);
        check_display({tag, " idle"}, question_bank(v.mode, v.op, STEP_IDLE, 1'b0));
        press_button(CONFIRM_BTN);
        check_display({tag, " enter a"}, question_bank(v.mode, v.op, STEP_ENTER_A, 1'b0));
        in = v.a;
        press_button(CONFIRM_BTN);
        check_display({tag, " enter b"}, question_bank(v.mode, v.op, STEP_ENTER_B, 1'b0));
        in = v.b;
        press_button(CONFIRM_BTN);
        check_display({tag, " enter answer"},
                      question_bank(v.mode, v.op, STEP_ENTER_ANSWER, 1'b0));
        in = v.answer;
        press_button(CONFIRM_BTN);
        check_display({tag, " verdict"}, question_bank(v.mode, v.op, STEP_VERDICT, v.correct));
        press_button(CONFIRM_BTN);
        check_display({tag, " back to idle"}, question_bank(v.mode, v.op, STEP_IDLE, 1'b0));
        press_button(EXIT_BTN);
        check_display({tag, " browse"}, browse_bank(cur_mode));
        attempts_exp[v.mode]++;
        if (v.correct)
            correct_exp[v.mode]++;
        extra = $urandom % 4;           // jitter between questions
        repeat (extra) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_exit_mid_question();
        select_browse_mode(2'd1);
        press_button(CONFIRM_BTN);
        press_button(CONFIRM_BTN);
        in = 8'h5c;
        press_button(CONFIRM_BTN);
        check_display("exit test enter b", question_bank(2'd1, 2'd0, STEP_ENTER_B, 1'b0));
        press_button(EXIT_BTN);
        check_value("exit test mode entered", 64'(1'b0), 64'(mode_entered));
        check_display("exit test browse", browse_bank(cur_mode));
    endtask

    task automatic check_statistics();
        int percent;
        press_button(DATA_BTN);
        for (int m = 0; m < NUM_MODES; m++) begin
            percent = (attempts_exp[m] == 0) ? 0 : correct_exp[m] * 100 / attempts_exp[m];
            check_display($sformatf("statistics mode %0d", m + 1),
                          stats_bank(2'(m), attempts_exp[m], percent));
            press_button(SELECT_BTN);
        end
        press_button(DATA_BTN);
        check_display("statistics closed", browse_bank(cur_mode));
    endtask

    initial begin
        confirm     = 1'b0;
        exit        = 1'b0;
        select      = 1'b0;
        data        = 1'b0;
        in          = '0;
        arst_n      = 1'b0;
        cur_mode    = 2'd0;
        error_count = 0;
        check_count = 0;
        for (int m = 0; m < NUM_MODES; m++) begin
            attempts_exp[m] = 0;
            correct_exp[m]  = 0;
        end
        void'($urandom(32'h0a9dff36));
        load_vectors();
        cycle_limit = 80 * vectors.size() + 600;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_value("reset mode entered", 64'(1'b0), 64'(mode_entered));
        check_display("reset display", browse_bank(2'd0));

        for (int i = 1; i <= 3; i++) begin
            step_browse_mode();
            check_display($sformatf("browse select %0d", i), browse_bank(cur_mode));
        end
        press_button(CONFIRM_BTN);
        check_value("browse confirm", 64'(1'b1), 64'(mode_entered));
        check_display("op 1", question_bank(cur_mode, 2'd0, STEP_IDLE, 1'b0));
        for (int i = 1; i <= 4; i++) begin
            press_button(SELECT_BTN);
            check_display($sformatf("op select %0d", i),
                          question_bank(cur_mode, 2'(i), STEP_IDLE, 1'b0));
        end
        press_button(EXIT_BTN);
        check_display("leave mode", browse_bank(cur_mode));

        for (int i = 0; i < vectors.size(); i++)
            run_question(i);
        check_exit_mid_question();
        check_statistics();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/quiz_pkg.sv
rtl/answer_unit.sv
rtl/quiz_control.sv
rtl/mode_tally.sv
rtl/seg_display.sv
rtl/quiz_trainer_top.sv
testbench/tb_quiz_trainer.sv
